// File: rv_exec_trace.txt
# kind name addr data expected_data expected_resp, all numbers in hex
# W writes data and checks bresp, R reads addr and checks rdata and rresp
W addi_seed_x1  00 ff900093 00000000 0
W lui_x2        00 12345137 00000000 0
R lui_read_x2   88 00000000 12345000 0
W addi_x2       00 67810113 00000000 0
W addi_seed_x3  00 00500193 00000000 0
W add           00 00308233 00000000 0
W sub           00 401182b3 00000000 0
W sll           00 00311333 00000000 0
W slt           00 0030a3b3 00000000 0
W sltu          00 0030b433 00000000 0
W xor           00 0020c4b3 00000000 0
W srl           00 0030d533 00000000 0
W sra           00 4030d5b3 00000000 0
W or            00 00316633 00000000 0
W and           00 0030f6b3 00000000 0
R add_read      90 00000000 fffffffe 0
R sub_read      94 00000000 0000000c 0
R sll_read      98 00000000 468acf00 0
R slt_read      9c 00000000 00000001 0
R sltu_read     a0 00000000 00000000 0
R xor_read      a4 00000000 edcba981 0
R srl_read      a8 00000000 07ffffff 0
R sra_read      ac 00000000 ffffffff 0
R or_read       b0 00000000 1234567d 0
R and_read      b4 00000000 00000001 0
W srai          00 4020d713 00000000 0
W srli          00 0020d793 00000000 0
W slti_neg      00 fff0a813 00000000 0
W sltiu_neg     00 fff1b893 00000000 0
W xori_neg      00 fff14913 00000000 0
R srai_read     b8 00000000 fffffffe 0
R srli_read     bc 00000000 3ffffffe 0
R slti_read     c0 00000000 00000001 0
R sltiu_read    c4 00000000 00000001 0
R xori_read     c8 00000000 edcba987 0
R addi_x2_read  88 00000000 12345678 0
W addi_x0       00 05500013 00000000 0
R x0_read       80 00000000 00000000 0
W illegal_load  00 0000a283 00000000 2
R status_full   04 00000000 00040014 0
R x5_unchanged  94 00000000 0000000c 0
R info_oldest   08 00000000 00001010 0
R data_oldest   0c 00000000 00000001 0
R info_second   08 00000000 00001111 0
R data_second   0c 00000000 00000001 0
R data_third    0c 00000000 edcba987 0
R info_x0_rec   08 00000000 00001300 0
R data_x0_rec   0c 00000000 00000000 0
R status_empty  04 00000000 00000014 0
R data_empty    0c 00000000 00000000 2
R info_empty    08 00000000 00000000 2
R unmapped      10 00000000 00000000 2

// File: filelist.f
rv_isa_pkg.sv
exec_bus_pkg.sv
instr_decoder.sv
reg_file.sv
arith_unit.sv
retire_tracer.sv
exec_control.sv
rv_exec_top.sv
rv_exec_props.sv
tb_rv_exec.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_exec
FILELIST   := filelist.f
FLAGS      := --timing --assert
SIM_FLAGS  := --binary -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_rv_exec.sv
/* rv32i execute unit testbench */
`timescale 1ns/100ps

module tb_rv_exec import exec_bus_pkg::*; ();

	localparam int    CLK_PERIOD      = 4;
	localparam int    RESET_CYCLES    = 5;
	localparam int    CYCLES_PER_LINE = 40; // budget per trace transaction
	localparam string TRACE_FILE      = "rv_exec_trace.txt";

	typedef struct packed {
		logic [7:0]      kind; // "W" or "R"
		logic [8*16-1:0] name;
		logic [7:0]      addr;
		logic [31:0]     data;
		logic [31:0]     exp_data;
		logic [1:0]      exp_resp;
	} trace_line_t;

	logic        clock;
	logic        reset;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	trace_line_t lines[$];
	logic        trace_loaded;
	int          errors;
	int          failed_tests;

	rv_exec_top #(.TRACE_DEPTH(4)) rv_exec_top_i (.clock, .reset, .axil_req, .axil_rsp);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic check(input logic [8*16-1:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %0s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic load_trace();
		int              fd;
		int              n;
		logic [8*128-1:0] text;
		logic [7:0]      kind;
		logic [8*16-1:0] name;
		logic [7:0]      addr;
		logic [31:0]     data;
		logic [31:0]     exp_data;
		logic [1:0]      exp_resp;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open trace file %0s", TRACE_FILE);
			return;
		end
		while (!$feof(fd)) begin
			text = '0;
			n = $fgets(text, fd);
			n = $sscanf(text, "%s %s %h %h %h %h", kind, name, addr, data, exp_data, exp_resp);
			// comment and blank lines never parse to six fields with a W/R kind
			if (n == 6 && (kind == "W" || kind == "R")) begin
				lines.push_back(trace_line_t'{kind, name, addr, data, exp_data, exp_resp});
			end
		end
		$fclose(fd);
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr <= addr;
		axil_req.wvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= 4'hf;
		@(negedge clock);
		while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clock);
		@(posedge clock); // aw/w handshake
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		@(negedge clock);
		while (!axil_rsp.bvalid) @(negedge clock);
		@(posedge clock); // b left waiting one cycle
		axil_req.bready <= 1'b1;
		@(negedge clock);
		while (!axil_rsp.bvalid) @(negedge clock);
		resp = axil_rsp.bresp;
		@(posedge clock); // b handshake
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr <= addr;
		@(negedge clock);
		while (!axil_rsp.arready) @(negedge clock);
		@(posedge clock);
		axil_req.arvalid <= 1'b0;
		@(negedge clock);
		while (!axil_rsp.rvalid) @(negedge clock);
		@(posedge clock); // r left waiting one cycle, no pop yet
		axil_req.rready <= 1'b1;
		@(negedge clock);
		while (!axil_rsp.rvalid) @(negedge clock);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clock); // r handshake, pops on trace data
		axil_req.rready <= 1'b0;
	endtask

	task automatic run_line(input trace_line_t t);
		logic [31:0] rdata;
		logic [1:0]  resp;
		int          errors_before;
		errors_before = errors;
		if (t.kind == "W") begin
			axil_write(t.addr, t.data, resp);
		end else begin
			axil_read(t.addr, rdata, resp);
			check(t.name, t.exp_data, rdata);
		end
		check(t.name, 32'(t.exp_resp), 32'(resp));
		if (errors == errors_before) begin
			$display("test %0s ok", t.name);
		end else begin
			failed_tests++;
			$display("test %0s had mismatches", t.name);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		axil_req = '0;
		errors = 0;
		failed_tests = 0;
		trace_loaded = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		foreach (lines[i]) run_line(lines[i]);
		$display("tests run %0d, failed %0d, mismatches %0d", lines.size(), failed_tests, errors);
		if (errors == 0 && lines.size() != 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (trace_loaded);
		repeat (lines.size() * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clock);
		$display("timeout: the DUT stopped answering before the trace was done");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: rv_exec_props.sv
/* host bus assertions */
`timescale 1ns/100ps

module rv_exec_props import exec_bus_pkg::*; (
	input logic      clock,
	input logic      reset,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp
);

	logic aw_fire, ar_fire;

	assign aw_fire = axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready;
	assign ar_fire = axil_req.arvalid && axil_rsp.arready;

	b_held: assert property (@(posedge clock) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else $error("write response dropped before bready");

	r_held: assert property (@(posedge clock) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else $error("read response dropped or changed before rready");

	// no new instruction while one executes or waits on B
	aw_busy: assert property (@(posedge clock) disable iff (reset)
		aw_fire |=> !axil_rsp.awready)
		else $error("awready high right after an accepted instruction");

	aw_resp: assert property (@(posedge clock) disable iff (reset)
		axil_rsp.bvalid |-> !axil_rsp.awready)
		else $error("awready high while a write response is pending");

	x0_zero: assert property (@(posedge clock) disable iff (reset)
		ar_fire && axil_req.araddr == ADDR_GPR_BASE |=> axil_rsp.rdata == 32'd0)
		else $error("x0 read back nonzero");

endmodule

bind rv_exec_top rv_exec_props rv_exec_props_i (.clock, .reset, .axil_req, .axil_rsp);

// File: rv_exec_top.sv
/* rv32i execute unit top */
`timescale 1ns/100ps

module rv_exec_top import rv_isa_pkg::*, exec_bus_pkg::*; #(
	parameter  int TRACE_DEPTH = 4,
	localparam int LW = $clog2(TRACE_DEPTH + 1)
) (
	input  logic      clock,
	input  logic      reset,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	instr_u        instr;
	decoded_t      dec;
	logic [4:0]    ra_idx, rb_idx, wb_idx;
	logic [31:0]   ra_data, rb_data, result, wb_data;
	logic          wb_en, push, pop;
	retire_rec_t   rec, head;
	logic [LW-1:0] level;

	exec_control #(.TRACE_DEPTH(TRACE_DEPTH)) exec_control_i (
		.clock, .reset, .axil_req, .axil_rsp,
		.instr, .dec,
		.ra_idx, .rb_idx, .ra_data, .result,
		.wb_en, .wb_idx, .wb_data,
		.push, .rec, .pop, .head, .level
	);

	instr_decoder instr_decoder_i (.instr, .dec);

	reg_file reg_file_i (
		.clock, .reset,
		.ra_idx, .rb_idx, .ra_data, .rb_data,
		.wb_en, .wb_idx, .wb_data
	);

	arith_unit arith_unit_i (
		.clock, .reset, .dec,
		.op_a(ra_data), .op_b(rb_data), .result
	);

	retire_tracer #(.TRACE_DEPTH(TRACE_DEPTH)) retire_tracer_i (
		.clock, .reset, .push, .rec, .pop, .head, .level
	);

endmodule

// File: exec_control.sv
/* execute sequencer and host port */
`timescale 1ns/100ps

module exec_control import rv_isa_pkg::*, exec_bus_pkg::*; #(
	parameter  int TRACE_DEPTH = 4,
	localparam int LW = $clog2(TRACE_DEPTH + 1)
) (
	input  logic          clock,
	input  logic          reset,
	input  axil_req_t     axil_req,
	output axil_rsp_t     axil_rsp,
	output instr_u        instr,
	input  decoded_t      dec,
	output logic [4:0]    ra_idx,
	output logic [4:0]    rb_idx,
	input  logic [31:0]   ra_data,
	input  logic [31:0]   result,
	output logic          wb_en,
	output logic [4:0]    wb_idx,
	output logic [31:0]   wb_data,
	output logic          push,
	output retire_rec_t   rec,
	output logic          pop,
	input  retire_rec_t   head,
	input  logic [LW-1:0] level
);

	typedef enum logic [1:0] {W_IDLE, W_EXEC, W_RESP} wstate_e;
	typedef enum logic {R_IDLE, R_RESP} rstate_e;

	wstate_e     wstate;
	rstate_e     rstate;
	instr_u      instr_q;
	logic        addr_ok_q, resp_err_q, retire_q, pop_q;
	logic [31:0] pc_q;
	logic [15:0] retired_q;
	logic        aw_fire, ar_fire, bad;
	logic [7:0]  gpr_off;
	logic [31:0] status, ar_data, rdata_q;
	logic [1:0]  ar_resp, rresp_q;
	logic        ar_pop;

	assign aw_fire = (wstate == W_IDLE) && axil_req.awvalid && axil_req.wvalid;
	assign bad = dec.illegal || !addr_ok_q; // refused before any state change

	always_ff @(posedge clock) begin
		if (reset) begin
			wstate <= W_IDLE;
			addr_ok_q <= 1'b0;
			resp_err_q <= 1'b0;
			retire_q <= 1'b0;
			pc_q <= '0;
			retired_q <= '0;
		end else begin
			retire_q <= (wstate == W_EXEC) && !bad; // first cycle of respond
			if (retire_q) begin
				pc_q <= pc_q + 32'd4;
				retired_q <= retired_q + 16'd1;
			end
			case (wstate)
				W_IDLE: if (aw_fire) begin
					addr_ok_q <= (axil_req.awaddr == ADDR_INSTR);
					wstate <= W_EXEC;
				end
				W_EXEC: begin
					resp_err_q <= bad;
					wstate <= (bad && axil_req.bready) ? W_IDLE : W_RESP;
				end
				W_RESP: if (axil_req.bready) wstate <= W_IDLE;
				default: wstate <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) instr_q.raw <= axil_req.wdata;
	end

	assign instr = instr_q;
	assign gpr_off = axil_req.araddr - ADDR_GPR_BASE;
	// gpr reads are held off while the regfile serves an instruction
	assign ra_idx = (wstate == W_EXEC) ? dec.rs1 : gpr_off[6:2];
	assign rb_idx = dec.rs2;

	assign wb_en = retire_q && dec.writes_rd;
	assign wb_idx = dec.rd;
	assign wb_data = result;
	assign push = retire_q;
	assign rec = '{pc: pc_q, rd: dec.rd, wdata: dec.writes_rd ? result : 32'd0};

	assign status = 32'(retired_q) | (32'(level) << 16);
	assign ar_fire = axil_req.arvalid && (rstate == R_IDLE) && (wstate != W_EXEC);

	always_comb begin
		ar_data = '0;
		ar_resp = RESP_OKAY;
		ar_pop = 1'b0;
		if (axil_req.araddr >= ADDR_GPR_BASE) begin
			if (axil_req.araddr[1:0] == 2'b00) ar_data = ra_data;
			else ar_resp = RESP_SLVERR;
		end else begin
			case (axil_req.araddr)
				ADDR_STATUS: ar_data = status;
				ADDR_TRACE_INFO, ADDR_TRACE_DATA: begin
					if (level == '0) begin
						ar_resp = RESP_SLVERR; // nothing traced
					end else if (axil_req.araddr == ADDR_TRACE_INFO) begin
						ar_data = {head.pc[25:2], 3'b000, head.rd};
					end else begin
						ar_data = head.wdata;
						ar_pop = 1'b1;
					end
				end
				default: ar_resp = RESP_SLVERR;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rstate <= R_IDLE;
			rresp_q <= RESP_OKAY;
			pop_q <= 1'b0;
		end else if (ar_fire) begin
			rstate <= R_RESP;
			rresp_q <= ar_resp;
			pop_q <= ar_pop;
		end else if (rstate == R_RESP && axil_req.rready) begin
			rstate <= R_IDLE;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) rdata_q <= ar_data;
	end

	assign pop = (rstate == R_RESP) && axil_req.rready && pop_q; // pop on R handshake

	always_comb begin
		axil_rsp = '0;
		axil_rsp.awready = (wstate == W_IDLE);
		axil_rsp.wready = (wstate == W_IDLE);
		axil_rsp.bvalid = (wstate == W_RESP) || (wstate == W_EXEC && bad);
		axil_rsp.bresp = (wstate == W_EXEC || resp_err_q) ? RESP_SLVERR : RESP_OKAY;
		axil_rsp.arready = (rstate == R_IDLE) && (wstate != W_EXEC);
		axil_rsp.rvalid = (rstate == R_RESP);
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = rresp_q;
	end

endmodule

// File: retire_tracer.sv
/* retirement trace fifo */
`timescale 1ns/100ps

module retire_tracer import exec_bus_pkg::*; #(
	parameter  int TRACE_DEPTH = 4,
	localparam int LW = $clog2(TRACE_DEPTH + 1),
	localparam int PW = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          push,
	input  retire_rec_t   rec,
	input  logic          pop,
	output retire_rec_t   head,
	output logic [LW-1:0] level
);

	retire_rec_t   mem [TRACE_DEPTH];
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic [LW-1:0] count;
	logic          full, do_pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		next_ptr = (p == PW'(TRACE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == LW'(TRACE_DEPTH));
	assign do_pop = pop && (count != '0); // empty pop ignored

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			// full push overwrites the oldest, so head moves on too
			if (do_pop || (push && full)) rd_ptr <= next_ptr(rd_ptr);
			if (push && !do_pop && !full) count <= count + 1'b1;
			else if (do_pop && !push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push) mem[wr_ptr] <= rec;
	end

	assign head = mem[rd_ptr];
	assign level = count;

endmodule

// File: arith_unit.sv
/* registered rv32i alu */
`timescale 1ns/100ps

module arith_unit import rv_isa_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  decoded_t    dec,
	input  logic [31:0] op_a,
	input  logic [31:0] op_b,
	output logic [31:0] result
);

	logic [31:0] src_b;
	logic [4:0]  shamt;
	logic [31:0] alu_out;

	assign src_b = dec.use_imm ? dec.imm : op_b;
	assign shamt = src_b[4:0]; // only low 5 bits shift

	always_comb begin
		case (dec.alu_op)
			ADD:     alu_out = op_a + src_b;
			SUB:     alu_out = op_a - src_b;
			SLL:     alu_out = op_a << shamt;
			SLT:     alu_out = {31'd0, $signed(op_a) < $signed(src_b)};
			SLTU:    alu_out = {31'd0, op_a < src_b};
			XOR:     alu_out = op_a ^ src_b;
			SRL:     alu_out = op_a >> shamt;
			SRA:     alu_out = 32'($signed(op_a) >>> shamt);
			OR:      alu_out = op_a | src_b;
			AND:     alu_out = op_a & src_b;
			LUI:     alu_out = dec.imm; // upper imm already shifted
			default: alu_out = '0;
		endcase
	end

	// result valid one cycle after the operands
	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
		end else begin
			result <= alu_out;
		end
	end

endmodule

// File: reg_file.sv
/* 32 x 32 register file */
`timescale 1ns/100ps

module reg_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_idx,
	input  logic [4:0]  rb_idx,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input  logic        wb_en,
	input  logic [4:0]  wb_idx,
	input  logic [31:0] wb_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_idx != 5'd0) begin
			regs[wb_idx] <= wb_data;
		end
	end

	// x0 forced to zero on read
	assign ra_data = (ra_idx == 5'd0) ? 32'd0 : regs[ra_idx];
	assign rb_data = (rb_idx == 5'd0) ? 32'd0 : regs[rb_idx];

endmodule

// File: instr_decoder.sv
/* rv32i instruction decoder */
`timescale 1ns/100ps

module instr_decoder import rv_isa_pkg::*; (
	input  instr_u   instr,
	output decoded_t dec
);

	// alt is funct7[5] / imm[10], the same bit 30 in both views
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			F3_ADD_SUB: alu_sel = (is_reg && alt) ? SUB : ADD; // no subi
			F3_SLL:     alu_sel = SLL;
			F3_SLT:     alu_sel = SLT;
			F3_SLTU:    alu_sel = SLTU;
			F3_XOR:     alu_sel = XOR;
			F3_SR:      alu_sel = alt ? SRA : SRL;
			F3_OR:      alu_sel = OR;
			F3_AND:     alu_sel = AND;
			default:    alu_sel = ADD;
		endcase
	endfunction

	always_comb begin
		dec = '0;
		dec.rd = instr.r.rd;
		dec.rs1 = instr.r.rs1;
		dec.rs2 = instr.r.rs2;
		dec.alu_op = ADD;
		case (instr.r.opcode)
			OP_REG: begin
				dec.alu_op = alu_sel(instr.r.funct3, instr.r.funct7[5], 1'b1);
			end
			OP_IMM: begin
				dec.use_imm = 1'b1;
				dec.imm = {{20{instr.i.imm12[11]}}, instr.i.imm12}; // sign extend
				dec.alu_op = alu_sel(instr.i.funct3, instr.i.imm12[10], 1'b0);
			end
			OP_LUI: begin
				dec.use_imm = 1'b1;
				dec.rs1 = 5'd0; // rs1 bits belong to imm20 here
				dec.imm = {instr.u.imm20, 12'h000};
				dec.alu_op = LUI;
			end
			default: dec.illegal = 1'b1;
		endcase
		dec.writes_rd = !dec.illegal && (dec.rd != 5'd0);
	end

endmodule

// File: exec_bus_pkg.sv
/* host bus and trace types */
package exec_bus_pkg;

	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] wdata;
	} retire_rec_t;

	// register map
	localparam logic [7:0] ADDR_INSTR      = 8'h00; // write only
	localparam logic [7:0] ADDR_STATUS     = 8'h04;
	localparam logic [7:0] ADDR_TRACE_INFO = 8'h08; // peek, no pop
	localparam logic [7:0] ADDR_TRACE_DATA = 8'h0C; // pops on R
	localparam logic [7:0] ADDR_GPR_BASE   = 8'h80; // xN at base + 4*N

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: rv_isa_pkg.sv
/* rv32i instruction formats */
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP_REG = 7'b0110011,
		OP_IMM = 7'b0010011,
		OP_LUI = 7'b0110111
	} opcode_e;

	// funct3 codes, shared by register and immediate forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // srl or sra
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t      r;
		i_fmt_t      i;
		u_fmt_t      u;
		logic [31:0] raw;
	} instr_u;

	typedef struct packed {
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		alu_op_e     alu_op;
		logic        use_imm;
		logic [31:0] imm;
		logic        writes_rd; // legal and rd != x0
		logic        illegal;
	} decoded_t;

endpackage
